/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic [isa_pkg::xlen-1:0]      a,
	input  logic [isa_pkg::xlen-1:0]      b,
	input  logic [core_pkg::alu_op_w-1:0] op,
	output logic [isa_pkg::xlen-1:0]      result,
	output logic                          zero
);

	import isa_pkg::*;
	import core_pkg::*;

	logic lt;

	assign lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_slt: result = {{(xlen-1){1'b0}}, lt};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // beq uses this after sub

	always_comb begin
		a_op_legal: assert final (op inside {alu_add, alu_sub, alu_and, alu_or, alu_slt})
			else $error("alu: undefined op %0h", op);
	end

endmodule : alu

`default_nettype wire

/* rtl/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  logic                           clk,
	input  logic                           rst_n,
	input  isa_pkg::instr_t                instr,
	input  logic                           alu_zero,
	output logic                           reg_we,
	output logic [core_pkg::alu_op_w-1:0]  alu_op,
	output logic                           alu_src_imm,
	output logic [core_pkg::imm_sel_w-1:0] imm_sel,
	output logic                           mem_to_reg,
	output logic                           mem_we,
	output logic                           branch_taken,
	output logic                           halt
);

	import isa_pkg::*;
	import core_pkg::*;

	logic reg_we_dec;
	logic mem_we_dec;
	logic is_beq;
	logic illegal;
	logic halt_q;
	logic wr_ok;

	always_comb begin
		reg_we_dec  = 1'b0;
		mem_we_dec  = 1'b0;
		alu_op      = alu_add;
		alu_src_imm = 1'b0;
		imm_sel     = imm_i;
		mem_to_reg  = 1'b0;
		is_beq      = 1'b0;
		illegal     = 1'b0;
		case (instr.r.opcode)
			op_rtype: begin
				reg_we_dec = 1'b1;
				case (instr.r.funct3)
					f3_add_sub: alu_op = (instr.r.funct7 == f7_sub) ? alu_sub : alu_add;
					f3_and:     alu_op = alu_and;
					f3_or:      alu_op = alu_or;
					f3_slt:     alu_op = alu_slt;
					default:    alu_op = alu_add;
				endcase
			end
			op_itype: begin // addi only
				reg_we_dec  = 1'b1;
				alu_src_imm = 1'b1;
			end
			op_load: begin
				reg_we_dec  = 1'b1;
				alu_src_imm = 1'b1;
				mem_to_reg  = 1'b1;
			end
			op_store: begin
				mem_we_dec  = 1'b1;
				alu_src_imm = 1'b1;
				imm_sel     = imm_s;
			end
			op_branch: begin
				alu_op  = alu_sub; // Equality via zero flag
				imm_sel = imm_b;
				is_beq  = (instr.r.funct3 == f3_beq);
			end
			default: illegal = 1'b1;
		endcase
	end

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halt_q <= 1'b0;
		end else if (illegal) begin
			halt_q <= 1'b1;
		end
	end

	assign wr_ok        = rst_n && !halt_q;
	assign reg_we       = reg_we_dec && wr_ok;
	assign mem_we       = mem_we_dec && wr_ok;
	assign branch_taken = is_beq && alu_zero && !halt_q;
	assign halt         = halt_q;

	a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		halt |=> halt && !reg_we && !mem_we)
		else $error("control_unit: write enable or halt drop after halt");

endmodule : control_unit

`default_nettype wire

/* rtl/core_pkg.sv */
`default_nettype none

package core_pkg;

	localparam int alu_op_w = 3;

	localparam logic [alu_op_w-1:0] alu_add = 3'd0;
	localparam logic [alu_op_w-1:0] alu_sub = 3'd1;
	localparam logic [alu_op_w-1:0] alu_and = 3'd2;
	localparam logic [alu_op_w-1:0] alu_or  = 3'd3;
	localparam logic [alu_op_w-1:0] alu_slt = 3'd4; // Signed compare

	localparam int imm_sel_w = 2;

	localparam logic [imm_sel_w-1:0] imm_i = 2'd0;
	localparam logic [imm_sel_w-1:0] imm_s = 2'd1;
	localparam logic [imm_sel_w-1:0] imm_b = 2'd2;

	// First fetch address after reset
	localparam logic [isa_pkg::xlen-1:0] reset_pc = 32'h0000_0000;

endpackage : core_pkg

`default_nettype wire

/* rtl/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
	input  isa_pkg::instr_t                instr,
	input  logic [core_pkg::imm_sel_w-1:0] imm_sel,
	output logic [isa_pkg::xlen-1:0]       imm
);

	import core_pkg::*;

	always_comb begin
		case (imm_sel)
			imm_i: imm = {{20{instr.i.imm12[11]}}, instr.i.imm12};
			imm_s: imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
			imm_b: begin // Halfword offset, bit 0 always zero
				imm = {{19{instr.b.imm_12}},
					instr.b.imm_12,
					instr.b.imm_11,
					instr.b.imm_10_5,
					instr.b.imm_4_1,
					1'b0};
			end
			default: imm = '0;
		endcase
	end

endmodule : imm_gen

`default_nettype wire

/* rtl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;

	// Major opcodes of the supported subset
	localparam logic [6:0] op_rtype  = 7'b0110011;
	localparam logic [6:0] op_itype  = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;
	localparam logic [2:0] f3_beq     = 3'b000;
	localparam logic [6:0] f7_sub     = 7'b0100000; // Selects sub over add

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// Branch offset bits are scattered over the word
	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
	} instr_t;

endpackage : isa_pkg

`default_nettype wire

/* rtl/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     branch_taken,
	input  logic                     halt,
	input  logic [isa_pkg::xlen-1:0] offset,
	output logic [isa_pkg::xlen-1:0] pc
);

	import isa_pkg::*;
	import core_pkg::*;

	logic [xlen-1:0] pc_next;

	always_comb begin
		if (halt) begin
			pc_next = pc; // Frozen until reset
		end else if (branch_taken) begin
			pc_next = pc + offset;
		end else begin
			pc_next = pc + xlen'(4);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= reset_pc;
		end else begin
			pc <= pc_next;
		end
	end

endmodule : pc_unit

`default_nettype wire

/* rtl/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           we,
	input  logic [isa_pkg::reg_addr_w-1:0] ra1,
	input  logic [isa_pkg::reg_addr_w-1:0] ra2,
	input  logic [isa_pkg::reg_addr_w-1:0] wa,
	input  logic [isa_pkg::xlen-1:0]       wd,
	output logic [isa_pkg::xlen-1:0]       rd1,
	output logic [isa_pkg::xlen-1:0]       rd2
);

	import isa_pkg::*;

	localparam int num_regs = 2 ** reg_addr_w;

	logic [xlen-1:0] regs [num_regs];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin // x0 never written
			regs[wa] <= wd;
		end
	end

	// Plain array reads, x0 stays zero from reset on
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

	a_x0_rd1: assert property (@(posedge clk) disable iff (!rst_n)
		(ra1 == '0) |-> (rd1 == '0))
		else $error("regfile: rd1 nonzero for x0");

	a_x0_rd2: assert property (@(posedge clk) disable iff (!rst_n)
		(ra2 == '0) |-> (rd2 == '0))
		else $error("regfile: rd2 nonzero for x0");

endmodule : regfile

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input  logic                     clk,
	input  logic                     rst_n,
	output logic [isa_pkg::xlen-1:0] imem_addr,
	input  logic [isa_pkg::xlen-1:0] imem_rdata,
	output logic [isa_pkg::xlen-1:0] dmem_addr,
	output logic [isa_pkg::xlen-1:0] dmem_wdata,
	output logic                     dmem_we,
	input  logic [isa_pkg::xlen-1:0] dmem_rdata,
	output logic                     halted
);

	import isa_pkg::*;
	import core_pkg::*;

	instr_t                instr;
	logic                  reg_we;
	logic [alu_op_w-1:0]   alu_op;
	logic                  alu_src_imm;
	logic [imm_sel_w-1:0]  imm_sel;
	logic                  mem_to_reg;
	logic                  branch_taken;
	logic                  alu_zero;
	logic [xlen-1:0]       rd1;
	logic [xlen-1:0]       rd2;
	logic [xlen-1:0]       imm;
	logic [xlen-1:0]       alu_b;
	logic [xlen-1:0]       alu_result;
	logic [xlen-1:0]       wb_data;
	logic [xlen-1:0]       pc;

	assign instr = imem_rdata;

	control_unit control_unit_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.alu_zero    (alu_zero),
		.reg_we      (reg_we),
		.alu_op      (alu_op),
		.alu_src_imm (alu_src_imm),
		.imm_sel     (imm_sel),
		.mem_to_reg  (mem_to_reg),
		.mem_we      (dmem_we),
		.branch_taken(branch_taken),
		.halt        (halted)
	);

	regfile regfile_inst (
		.clk  (clk),
		.rst_n(rst_n),
		.we   (reg_we),
		.ra1  (instr.r.rs1),
		.ra2  (instr.r.rs2),
		.wa   (instr.r.rd),
		.wd   (wb_data),
		.rd1  (rd1),
		.rd2  (rd2)
	);

	imm_gen imm_gen_inst (
		.instr  (instr),
		.imm_sel(imm_sel),
		.imm    (imm)
	);

	assign alu_b = alu_src_imm ? imm : rd2;

	alu alu_inst (
		.a     (rd1),
		.b     (alu_b),
		.op    (alu_op),
		.result(alu_result),
		.zero  (alu_zero)
	);

	// Loads return data, everything else writes the ALU result
	assign wb_data = mem_to_reg ? dmem_rdata : alu_result;

	assign dmem_addr  = alu_result;
	assign dmem_wdata = rd2;

	pc_unit pc_unit_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.branch_taken(branch_taken),
		.halt        (halted),
		.offset      (imm),
		.pc          (pc)
	);

	assign imem_addr = pc;

endmodule : rv_core

`default_nettype wire

/* rv_core.f */
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/regfile.sv
rtl/control_unit.sv
rtl/imm_gen.sv
rtl/alu.sv
rtl/pc_unit.sv
rtl/rv_core.sv
tb/tb_rv_core.sv

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

	import isa_pkg::*;
	import core_pkg::*;

	localparam int reset_cycles = 10;
	localparam int wait_limit   = 50;
	localparam int dmem_words   = 64;

	typedef struct {
		logic [xlen-1:0] instr;
		logic [xlen-1:0] pc;
		logic            we;
		logic [xlen-1:0] addr;
		logic [xlen-1:0] data;
		logic            halted;
	} row_t;

	logic            clk;
	logic            rst_n;
	logic [xlen-1:0] imem_addr;
	logic [xlen-1:0] imem_rdata;
	logic [xlen-1:0] dmem_addr;
	logic [xlen-1:0] dmem_wdata;
	logic            dmem_we;
	logic [xlen-1:0] dmem_rdata;
	logic            halted;

	logic [xlen-1:0] dmem [dmem_words];
	row_t            rows[$];
	int              value_errors;
	int              timeouts;

	rv_core rv_core_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.imem_addr (imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_addr (dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we   (dmem_we),
		.dmem_rdata(dmem_rdata),
		.halted    (halted)
	);

	always #2 clk = ~clk;

	assign dmem_rdata = dmem[dmem_addr[7:2]]; // Word index from byte address

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[7:2]] <= dmem_wdata;
		end
	end

	function automatic logic [31:0] rtype_word(input logic [6:0] funct7,
		input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] addi_word(input logic [4:0] rd,
		input logic [4:0] rs1, input int imm);
		logic [31:0] v;
		v = imm;
		return {v[11:0], rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] lw_word(input logic [4:0] rd,
		input logic [4:0] rs1, input int imm);
		logic [31:0] v;
		v = imm;
		return {v[11:0], rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] sw_word(input logic [4:0] rs2,
		input logic [4:0] rs1, input int imm);
		logic [31:0] v;
		v = imm;
		return {v[11:5], rs2, rs1, 3'b010, v[4:0], 7'b0100011};
	endfunction

	// Offset is in bytes, bit 0 dropped by the format
	function automatic logic [31:0] beq_word(input logic [4:0] rs1,
		input logic [4:0] rs2, input int imm);
		logic [31:0] v;
		v = imm;
		return {v[12], v[10:5], rs2, rs1, 3'b000, v[4:1], v[11], 7'b1100011};
	endfunction

	task automatic add_row(input logic [31:0] instr, input logic [31:0] pc,
		input logic we, input logic [31:0] addr, input logic [31:0] data,
		input logic exp_halted);
		row_t r;
		r.instr  = instr;
		r.pc     = pc;
		r.we     = we;
		r.addr   = addr;
		r.data   = data;
		r.halted = exp_halted;
		rows.push_back(r);
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("FAILED %s: expected %h, got %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic build_program();
		add_row(addi_word(1, 0, 90), 32'h00, 0, 0, 0, 0);
		add_row(addi_word(2, 0, -7), 32'h04, 0, 0, 0, 0);
		add_row(sw_word(1, 0, 0), 32'h08, 1, 32'h00, 32'h0000_005a, 0);
		add_row(sw_word(2, 0, 4), 32'h0c, 1, 32'h04, 32'hffff_fff9, 0);
		add_row(rtype_word(7'h00, 3'b000, 3, 1, 2), 32'h10, 0, 0, 0, 0); // add
		add_row(sw_word(3, 0, 8), 32'h14, 1, 32'h08, 32'h0000_0053, 0);
		add_row(rtype_word(7'h20, 3'b000, 4, 1, 2), 32'h18, 0, 0, 0, 0); // sub
		add_row(sw_word(4, 0, 12), 32'h1c, 1, 32'h0c, 32'h0000_0061, 0);
		add_row(rtype_word(7'h00, 3'b111, 5, 1, 2), 32'h20, 0, 0, 0, 0); // and
		add_row(sw_word(5, 0, 16), 32'h24, 1, 32'h10, 32'h0000_0058, 0);
		add_row(rtype_word(7'h00, 3'b110, 6, 1, 2), 32'h28, 0, 0, 0, 0); // or
		add_row(sw_word(6, 0, 20), 32'h2c, 1, 32'h14, 32'hffff_fffb, 0);
		add_row(rtype_word(7'h00, 3'b010, 7, 2, 1), 32'h30, 0, 0, 0, 0); // -7 < 90
		add_row(sw_word(7, 0, 24), 32'h34, 1, 32'h18, 32'h0000_0001, 0);
		add_row(rtype_word(7'h00, 3'b010, 8, 1, 2), 32'h38, 0, 0, 0, 0); // 90 < -7
		add_row(sw_word(8, 0, 28), 32'h3c, 1, 32'h1c, 32'h0000_0000, 0);
		add_row(addi_word(0, 0, 123), 32'h40, 0, 0, 0, 0); // Discarded write
		add_row(sw_word(0, 0, 32), 32'h44, 1, 32'h20, 32'h0000_0000, 0);
		add_row(addi_word(9, 0, -300), 32'h48, 0, 0, 0, 0);
		add_row(sw_word(9, 0, 36), 32'h4c, 1, 32'h24, 32'hffff_fed4, 0);
		add_row(lw_word(10, 0, 36), 32'h50, 0, 0, 0, 0);
		add_row(sw_word(10, 1, -50), 32'h54, 1, 32'h28, 32'hffff_fed4, 0);
		add_row(beq_word(1, 1, 12), 32'h58, 0, 0, 0, 0); // Taken
		add_row(beq_word(1, 2, 8), 32'h64, 0, 0, 0, 0); // Not taken
		add_row(sw_word(3, 0, 44), 32'h68, 1, 32'h2c, 32'h0000_0053, 0);
		add_row(32'hffff_ffff, 32'h6c, 0, 0, 0, 0); // Unknown opcode
		add_row(sw_word(1, 0, 48), 32'h70, 0, 0, 0, 1);
		add_row(addi_word(1, 0, 1), 32'h70, 0, 0, 0, 1);
		add_row(beq_word(0, 0, -8), 32'h70, 0, 0, 0, 1);
		add_row(sw_word(2, 0, 52), 32'h70, 0, 0, 0, 1);
	endtask

	task automatic apply_row(input row_t r);
		check_word("imem_addr", r.pc, imem_addr);
		imem_rdata = r.instr;
		#0.5;
		check_word("dmem_we", r.we, dmem_we);
		if (r.we) begin
			check_word("dmem_addr", r.addr, dmem_addr);
			check_word("dmem_wdata", r.data, dmem_wdata);
		end
		check_word("halted", r.halted, halted);
	endtask

	initial begin
		int cycles;
		clk          = 1'b0;
		rst_n        = 1'b0;
		imem_rdata   = sw_word(1, 0, 0); // Store held off by reset
		value_errors = 0;
		timeouts     = 0;
		for (int i = 0; i < dmem_words; i++) begin
			dmem[i] = 32'hc0de_0000 | (i << 2);
		end
		build_program();

		for (cycles = 0; cycles < reset_cycles; cycles++) begin
			@(posedge clk);
		end
		@(negedge clk);
		cycles = 0;
		while ((imem_addr !== reset_pc || halted !== 1'b0) && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles == wait_limit) begin
			$display("ERROR: core never settled at the reset pc with halted low");
			timeouts++;
		end
		check_word("imem_addr", reset_pc, imem_addr);
		check_word("dmem_we", 0, dmem_we);
		check_word("halted", 0, halted);
		rst_n = 1'b1;

		foreach (rows[i]) begin
			if (i != 0) begin
				@(negedge clk);
			end
			apply_row(rows[i]);
		end

		cycles = 0;
		while (halted !== 1'b1 && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles == wait_limit) begin
			$display("ERROR: core did not halt after the unknown opcode");
			timeouts++;
		end
		@(negedge clk);
		check_word("imem_addr", rows[rows.size()-1].pc, imem_addr); // Still frozen

		$display("tb_rv_core: %0d value errors, %0d timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule : tb_rv_core

`default_nettype wire
